//--- logic/cpuControlPkg.sv
// Shared types for the control unit; opcodes above RET and the stack/SP opcodes have no names
`default_nettype none

package cpuControlPkg;

    // Raw 6-bit opcode as fetched
    typedef logic [5:0] opcodeT;

    // Opcode encodings of the supported instructions
    localparam opcodeT opRType = 6'd0;

    // Immediate ALU group
    localparam opcodeT opAddi = 6'd1;
    localparam opcodeT opSubi = 6'd2;
    localparam opcodeT opAndi = 6'd3;
    localparam opcodeT opOri  = 6'd4;
    localparam opcodeT opXori = 6'd5;
    localparam opcodeT opNoti = 6'd6;
    localparam opcodeT opSlai = 6'd7;
    localparam opcodeT opSrli = 6'd8;
    localparam opcodeT opSrai = 6'd9;

    // Branch group
    localparam opcodeT opBr  = 6'd10;
    localparam opcodeT opBmi = 6'd11;
    localparam opcodeT opBpl = 6'd12;
    localparam opcodeT opBz  = 6'd13;

    // Memory access
    localparam opcodeT opLd = 6'd14;
    localparam opcodeT opSt = 6'd15;

    // Register copy, done as Rs + 0
    localparam opcodeT opMove = 6'd18;

    // Miscellaneous
    localparam opcodeT opHalt = 6'd22;
    localparam opcodeT opNop  = 6'd23;

    // ALU operation code
    // Zero tells the ALU to use the R-type function field
    typedef logic [3:0] aluOpT;

    // Address and target arithmetic
    localparam aluOpT aluAdd = 4'd1;

    // Branch condition selector for the PC unit
    typedef enum logic [2:0] {
        brNone   = 3'd0,
        brAlways = 3'd1,
        brPlus   = 3'd2,
        brMinus  = 3'd3,
        brZero   = 3'd4
    } branchOpT;

    // Sequence class chosen by the decoder
    typedef enum logic [2:0] {
        clsAluReg,
        clsAluImm,
        clsBranch,
        clsLoad,
        clsStore,
        clsNop,
        clsHalt,
        clsIllegal
    } instrClassE;

    // Per-step datapath controls, 13 bits
    typedef struct packed {
        branchOpT branchOp;
        aluOpT    aluOp;
        logic     aluSrc;
        logic     regDst;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     memToReg;
    } ctrlWordT;

    // Decoder result
    // Base only fills branchOp, aluOp, aluSrc and regDst
    typedef struct packed {
        instrClassE instrClass;
        ctrlWordT   base;
    } decodedInstrT;

endpackage

`default_nettype wire

//--- logic/opcodeDecoder.sv
// Purely combinational; unknown, stack and SP opcodes all decode as illegal with a zero base
`timescale 1ns/1ps
`default_nettype none

module opcodeDecoder (
    input  cpuControlPkg::opcodeT       opcode,
    output cpuControlPkg::decodedInstrT decoded
);

    always_comb begin
        // Anything not listed below stays illegal with all base fields clear
        decoded            = '0;
        decoded.instrClass = cpuControlPkg::clsIllegal;

        case (opcode)
            cpuControlPkg::opRType: begin
                // ALU takes its function field
                decoded.instrClass  = cpuControlPkg::clsAluReg;
                decoded.base.aluOp  = 4'd0;
                decoded.base.regDst = 1'b1;
            end

            cpuControlPkg::opAddi,
            cpuControlPkg::opSubi,
            cpuControlPkg::opAndi,
            cpuControlPkg::opOri,
            cpuControlPkg::opXori,
            cpuControlPkg::opNoti,
            cpuControlPkg::opSlai,
            cpuControlPkg::opSrli,
            cpuControlPkg::opSrai: begin
                // Low opcode bits are the ALU operation
                decoded.instrClass  = cpuControlPkg::clsAluImm;
                decoded.base.aluOp  = opcode[3:0];
                decoded.base.aluSrc = 1'b1;
            end

            cpuControlPkg::opMove: begin
                // Rt = Rs + 0 through the immediate path
                decoded.instrClass  = cpuControlPkg::clsAluImm;
                decoded.base.aluOp  = cpuControlPkg::aluAdd;
                decoded.base.aluSrc = 1'b1;
            end

            cpuControlPkg::opBr: begin
                decoded.instrClass    = cpuControlPkg::clsBranch;
                decoded.base.branchOp = cpuControlPkg::brAlways;
                decoded.base.aluOp    = cpuControlPkg::aluAdd;
                decoded.base.aluSrc   = 1'b1;
            end

            cpuControlPkg::opBpl: begin
                decoded.instrClass    = cpuControlPkg::clsBranch;
                decoded.base.branchOp = cpuControlPkg::brPlus;
                decoded.base.aluOp    = cpuControlPkg::aluAdd;
                decoded.base.aluSrc   = 1'b1;
            end

            cpuControlPkg::opBmi: begin
                decoded.instrClass    = cpuControlPkg::clsBranch;
                decoded.base.branchOp = cpuControlPkg::brMinus;
                decoded.base.aluOp    = cpuControlPkg::aluAdd;
                decoded.base.aluSrc   = 1'b1;
            end

            cpuControlPkg::opBz: begin
                decoded.instrClass    = cpuControlPkg::clsBranch;
                decoded.base.branchOp = cpuControlPkg::brZero;
                decoded.base.aluOp    = cpuControlPkg::aluAdd;
                decoded.base.aluSrc   = 1'b1;
            end

            cpuControlPkg::opLd: begin
                // Address is base register plus immediate
                decoded.instrClass  = cpuControlPkg::clsLoad;
                decoded.base.aluOp  = cpuControlPkg::aluAdd;
                decoded.base.aluSrc = 1'b1;
            end

            cpuControlPkg::opSt: begin
                decoded.instrClass  = cpuControlPkg::clsStore;
                decoded.base.aluOp  = cpuControlPkg::aluAdd;
                decoded.base.aluSrc = 1'b1;
            end

            cpuControlPkg::opNop: begin
                decoded.instrClass = cpuControlPkg::clsNop;
            end

            cpuControlPkg::opHalt: begin
                decoded.instrClass = cpuControlPkg::clsHalt;
            end

            default: begin
                decoded.instrClass = cpuControlPkg::clsIllegal;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/stepSequencer.sv
// aluSettleCycles must be 1 to 4; ctrl has no back-pressure and HALT is only left through reset
`timescale 1ns/1ps
`default_nettype none

module stepSequencer #(
    parameter int aluSettleCycles = 1
) (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        instrValid,
    input  cpuControlPkg::decodedInstrT decoded,
    output logic                        instrReady,
    output cpuControlPkg::ctrlWordT     ctrl,
    output logic                        pcUpdate,
    output logic                        illegalOp,
    output logic                        halted
);

    typedef enum logic [1:0] {
        stIdle,
        stRunning,
        stHalted
    } seqStateE;

    seqStateE                    state;
    cpuControlPkg::decodedInstrT instr;
    logic [2:0]                  stepCnt;
    logic [2:0]                  lastStep;
    logic                        running;
    logic                        isLast;
    logic                        transfer;

    // Handshake only completes while idle
    assign instrReady = (state == stIdle);
    assign transfer   = instrValid && instrReady;
    assign running    = (state == stRunning);
    assign halted     = (state == stHalted);

    // Index of the final step per class
    always_comb begin
        case (instr.instrClass)
            cpuControlPkg::clsBranch: lastStep = 3'(aluSettleCycles + 1);
            cpuControlPkg::clsLoad:   lastStep = 3'd3;
            cpuControlPkg::clsStore:  lastStep = 3'(aluSettleCycles + 2);
            default:                  lastStep = 3'd0;
        endcase
    end

    assign isLast = (stepCnt == lastStep);

    // State and step counter
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= stIdle;
            stepCnt <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (transfer) begin
                        // HALT never runs a step
                        if (decoded.instrClass == cpuControlPkg::clsHalt) begin
                            state <= stHalted;
                        end else begin
                            state   <= stRunning;
                            stepCnt <= '0;
                        end
                    end
                end

                stRunning: begin
                    if (isLast) begin
                        state <= stIdle;
                    end else begin
                        stepCnt <= stepCnt + 3'd1;
                    end
                end

                default: begin
                    // Parked until arstN
                    state <= stHalted;
                end
            endcase
        end
    end

    // Decode captured on the accepting edge
    always_ff @(posedge clk) begin
        if (transfer) begin
            instr <= decoded;
        end
    end

    // Control word for the current step
    always_comb begin
        ctrl = '0;
        if (running) begin
            case (instr.instrClass)
                cpuControlPkg::clsAluReg,
                cpuControlPkg::clsAluImm: begin
                    // Single step writing the result
                    ctrl          = instr.base;
                    ctrl.regWrite = 1'b1;
                end

                cpuControlPkg::clsBranch: begin
                    // Same word held while the target add settles
                    ctrl = instr.base;
                end

                cpuControlPkg::clsLoad: begin
                    ctrl = instr.base;
                    // Memory read on step 1
                    if (stepCnt == 3'd1) begin
                        ctrl.memRead = 1'b1;
                    end
                    // Writeback on step 2
                    if (stepCnt == 3'd2) begin
                        ctrl.memToReg = 1'b1;
                        ctrl.regWrite = 1'b1;
                    end
                end

                cpuControlPkg::clsStore: begin
                    ctrl = instr.base;
                    // Write strobe just before the pcUpdate step
                    if (stepCnt == lastStep - 3'd1) begin
                        ctrl.memWrite = 1'b1;
                    end
                end

                default: begin
                    // NOP and illegal drive nothing
                    ctrl = '0;
                end
            endcase
        end
    end

    assign pcUpdate  = running && isLast;
    assign illegalOp = running && (instr.instrClass == cpuControlPkg::clsIllegal);

endmodule

`default_nettype wire

//--- logic/cpuControl.sv
// Top of the control unit; opcode must stay stable while instrValid is high and instrReady low
`timescale 1ns/1ps
`default_nettype none

module cpuControl #(
    parameter int aluSettleCycles = 1
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    instrValid,
    input  cpuControlPkg::opcodeT   opcode,
    output logic                    instrReady,
    output cpuControlPkg::ctrlWordT ctrl,
    output logic                    pcUpdate,
    output logic                    illegalOp,
    output logic                    halted
);

    cpuControlPkg::decodedInstrT decoded;

    // Zero-latency opcode table
    opcodeDecoder uDecoder (
        .opcode  (opcode),
        .decoded (decoded)
    );

    // Step engine
    stepSequencer #(
        .aluSettleCycles (aluSettleCycles)
    ) uSequencer (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .decoded    (decoded),
        .instrReady (instrReady),
        .ctrl       (ctrl),
        .pcUpdate   (pcUpdate),
        .illegalOp  (illegalOp),
        .halted     (halted)
    );

endmodule

`default_nettype wire

//--- include/cpuControlChecks.svh
// Include inside the testbench module only; counters live in that module and the LFSR is 17 bits
`ifndef CPU_CONTROL_CHECKS_SVH
`define CPU_CONTROL_CHECKS_SVH

// Mismatch counters
int ctrlErrors = 0;
int bitErrors  = 0;

// Full control word compare
task automatic compareCtrl(input cpuControlPkg::ctrlWordT actual,
                           input cpuControlPkg::ctrlWordT expected,
                           input string                   what);
    if (actual !== expected) begin
        ctrlErrors++;
        $display("Error at %0t: %s ctrl got %h expected %h (br=%0d alu=%0d src=%b dst=%b %s",
                 $time, what, actual, expected,
                 actual.branchOp, actual.aluOp, actual.aluSrc, actual.regDst,
                 $sformatf("rw=%b mr=%b mw=%b m2r=%b)",
                           actual.regWrite, actual.memRead, actual.memWrite,
                           actual.memToReg));
    end
endtask

// Single status bit compare
task automatic compareBit(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
        bitErrors++;
        $display("Error at %0t: %s got %b expected %b", $time, what, actual, expected);
    end
endtask

// Fibonacci LFSR x^17 + x^14 + 1, one shift per call
function automatic logic [16:0] lfsrNext(input logic [16:0] state);
    logic feedback;
    feedback = state[16] ^ state[13];
    return {state[15:0], feedback};
endfunction

// Sum for the closing report
function automatic int totalErrors();
    return ctrlErrors + bitErrors;
endfunction

`endif

//--- bench/cpuControlTb.sv
// Directed testbench at aluSettleCycles 2; needs the include folder on the search path
`timescale 1ns/1ps
`default_nettype none

module cpuControlTb;

    localparam int settle = 2;

    logic                    clk;
    logic                    arstN;
    logic                    instrValid;
    cpuControlPkg::opcodeT   opcode;
    logic                    instrReady;
    cpuControlPkg::ctrlWordT ctrl;
    logic                    pcUpdate;
    logic                    illegalOp;
    logic                    halted;
    logic [16:0]             lfsr = 17'd90496;

    `include "cpuControlChecks.svh"

    cpuControl #(.aluSettleCycles(settle)) u_dut (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .opcode(opcode),
        .instrReady(instrReady), .ctrl(ctrl), .pcUpdate(pcUpdate),
        .illegalOp(illegalOp), .halted(halted)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Sequence length per class
    function automatic int expectedSteps(input cpuControlPkg::opcodeT op);
        if (op >= cpuControlPkg::opBr && op <= cpuControlPkg::opBz) return 2 + settle;
        if (op == cpuControlPkg::opLd) return 4;
        if (op == cpuControlPkg::opSt) return 3 + settle;
        return 1;
    endfunction

    // Anything outside the kept set
    function automatic logic expectedIllegal(input cpuControlPkg::opcodeT op);
        return !(op <= cpuControlPkg::opSt || op == cpuControlPkg::opMove ||
                 op == cpuControlPkg::opHalt || op == cpuControlPkg::opNop);
    endfunction

    // Reference control word for one step
    function automatic cpuControlPkg::ctrlWordT expectedCtrl(input cpuControlPkg::opcodeT op,
                                                           input int step);
        cpuControlPkg::ctrlWordT w;
        int n;
        w = '0;
        n = expectedSteps(op);
        if (op == cpuControlPkg::opRType) begin
            w.regDst   = 1'b1;
            w.regWrite = 1'b1;
        end else if (op <= cpuControlPkg::opSrai || op == cpuControlPkg::opMove) begin
            // MOVE rides the immediate path as an add
            w.aluOp    = (op == cpuControlPkg::opMove) ? cpuControlPkg::aluAdd : op[3:0];
            w.aluSrc   = 1'b1;
            w.regWrite = 1'b1;
        end else if (op <= cpuControlPkg::opSt) begin
            // Branch, load and store all add base and offset
            w.aluOp  = cpuControlPkg::aluAdd;
            w.aluSrc = 1'b1;
            case (op)
                cpuControlPkg::opBr:  w.branchOp = cpuControlPkg::brAlways;
                cpuControlPkg::opBmi: w.branchOp = cpuControlPkg::brMinus;
                cpuControlPkg::opBpl: w.branchOp = cpuControlPkg::brPlus;
                cpuControlPkg::opBz:  w.branchOp = cpuControlPkg::brZero;
                default:              w.branchOp = cpuControlPkg::brNone;
            endcase
            if (op == cpuControlPkg::opLd) begin
                w.memRead  = (step == 1);
                w.memToReg = (step == 2);
                w.regWrite = (step == 2);
            end
            // Write strobe one step before pcUpdate
            if (op == cpuControlPkg::opSt) w.memWrite = (step == n - 2);
        end
        return w;
    endfunction

    // Called just after a rising edge
    task automatic waitReady();
        int waited;
        waited = 0;
        while (instrReady !== 1'b1) begin
            if (waited >= 50) begin
                $display("Timed out waiting for instrReady");
                $display("Test failures found");
                $finish;
            end
            @(posedge clk);
            #2;
            waited++;
        end
    endtask

    // Issue one opcode and check every step up to pcUpdate
    task automatic runInstr(input cpuControlPkg::opcodeT op);
        int steps;
        waitReady();
        instrValid = 1'b1;
        opcode     = op;
        @(posedge clk);
        #2;
        instrValid = 1'b0;
        steps = 0;
        do begin
            // Mid-cycle sample of the step outputs
            @(negedge clk);
            compareCtrl(ctrl, expectedCtrl(op, steps), $sformatf("op %0d step %0d", op, steps));
            compareBit(illegalOp, expectedIllegal(op), $sformatf("op %0d illegalOp", op));
            compareBit(instrReady, 1'b0, $sformatf("op %0d ready in step", op));
            steps++;
            if (pcUpdate !== 1'b1 && steps >= 16) begin
                $display("No pcUpdate for opcode %0d after 16 steps", op);
                $display("Test failures found");
                $finish;
            end
        end while (pcUpdate !== 1'b1);
        compareBit(steps == expectedSteps(op), 1'b1, $sformatf("op %0d steps %0d", op, steps));
        // Ready one cycle after the pcUpdate step
        @(posedge clk);
        #2;
        compareBit(instrReady, 1'b1, $sformatf("op %0d ready after pcUpdate", op));
        compareCtrl(ctrl, '0, "idle ctrl");
    endtask

    task automatic applyReset();
        arstN      = 1'b0;
        instrValid = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        arstN = 1'b1;
    endtask

    task automatic resetStateTest();
        compareBit(instrReady, 1'b1, "reset instrReady");
        compareCtrl(ctrl, '0, "reset ctrl");
        compareBit(pcUpdate, 1'b0, "reset pcUpdate");
        compareBit(illegalOp, 1'b0, "reset illegalOp");
        compareBit(halted, 1'b0, "reset halted");
    endtask

    task automatic aluTest();
        for (int op = 0; op <= 9; op++) runInstr(cpuControlPkg::opcodeT'(op));
        runInstr(cpuControlPkg::opMove);
    endtask

    task automatic branchTest();
        for (int op = cpuControlPkg::opBr; op <= cpuControlPkg::opBz; op++) begin
            runInstr(cpuControlPkg::opcodeT'(op));
        end
    endtask

    task automatic loadStoreTest();
        runInstr(cpuControlPkg::opLd);
        runInstr(cpuControlPkg::opSt);
    endtask

    // 40 LFSR opcodes, six shifts each
    task automatic randomTest();
        cpuControlPkg::opcodeT op;
        int issued;
        issued = 0;
        while (issued < 40) begin
            for (int b = 0; b < 6; b++) begin
                lfsr = lfsrNext(lfsr);
                op   = {op[4:0], lfsr[0]};
            end
            if (op != cpuControlPkg::opHalt) begin
                runInstr(op);
                issued++;
            end
        end
    endtask

    task automatic haltTest();
        waitReady();
        instrValid = 1'b1;
        opcode     = cpuControlPkg::opHalt;
        // Transfer edge
        @(posedge clk);
        #2;
        // Valid stays high the whole time
        repeat (20) begin
            @(negedge clk);
            compareBit(halted, 1'b1, "halted");
            compareBit(instrReady, 1'b0, "ready while halted");
            compareBit(pcUpdate, 1'b0, "pcUpdate while halted");
            compareCtrl(ctrl, '0, "ctrl while halted");
        end
        @(posedge clk);
        #2;
        applyReset();
        compareBit(halted, 1'b0, "halted after reset");
        compareBit(instrReady, 1'b1, "ready after reset");
    endtask

    initial begin
        arstN      = 1'b0;
        instrValid = 1'b0;
        opcode     = '0;
        applyReset();
        resetStateTest();
        aluTest();
        branchTest();
        loadStoreTest();
        randomTest();
        haltTest();
        $display("ctrl errors %0d, bit errors %0d, total %0d",
                 ctrlErrors, bitErrors, totalErrors());
        if (totalErrors() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cpuControl.f
+incdir+include
logic/cpuControlPkg.sv
logic/opcodeDecoder.sv
logic/stepSequencer.sv
logic/cpuControl.sv
bench/cpuControlTb.sv
